// File: common/lane_seq_pkg.sv
/*
  Shared types and sizes for the lane sequencer.
  NR_LANES must be a power of two, since the lane split uses shifts.
  Only the ALU and MFPU units exist; there are no hazard fields.
*/
package lane_seq_pkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////

  localparam int unsigned NR_LANES   = 4;
  localparam int unsigned NR_VINSN   = 8;
  localparam int unsigned VL_W       = 16;
  localparam int unsigned VREG_W     = 5;
  localparam int unsigned LANE_ID_W  = $clog2(NR_LANES);
  localparam int unsigned NR_OPQ     = 6;

  // Index of the mask register v0
  localparam logic [VREG_W-1:0] VMASK = '0;

  // One mask word covers 8 bytes in each lane
  localparam int unsigned MASK_SHIFT = $clog2(NR_LANES * 8);

  ////////////////////////////////////////
  // Enums
  ////////////////////////////////////////

  typedef enum logic {
    VFU_ALU,
    VFU_MFPU
  } vfu_e;

  typedef enum logic [3:0] {
    OP_VADD,
    OP_VSUB,
    OP_VAND,
    OP_VMUL,
    OP_VFADD,
    OP_VFMACC,
    OP_VREDSUM,
    OP_VFREDSUM
  } vinsn_op_e;

  typedef enum logic [1:0] {
    EW8,
    EW16,
    EW32,
    EW64
  } vsew_e;

  // Operand queues in the order of the command array
  typedef enum logic [2:0] {
    OPQ_ALU_A,
    OPQ_ALU_B,
    OPQ_MFPU_A,
    OPQ_MFPU_B,
    OPQ_MFPU_C,
    OPQ_MASK_M
  } opq_e;

  typedef logic [$clog2(NR_VINSN)-1:0] vinsn_id_t;

  ////////////////////////////////////////
  // Structs
  ////////////////////////////////////////

  typedef struct packed {
    vinsn_id_t         id;
    vinsn_op_e         op;
    vfu_e              vfu;
    logic              vm;       // 1 means unmasked
    logic [VREG_W-1:0] vs1;
    logic [VREG_W-1:0] vs2;
    logic [VREG_W-1:0] vd;
    logic              use_vs1;
    logic              use_vs2;
    logic              use_vd_op;
    logic              swap_vs2_vd_op;
    logic [VL_W-1:0]   vl;
    logic [VL_W-1:0]   vstart;
    vsew_e             vsew;
  } pe_req_t;

  typedef struct packed {
    logic [NR_VINSN-1:0] vinsn_done;
  } pe_resp_t;

  // The vl and vstart here are the lane's share of the instruction
  typedef struct packed {
    vinsn_id_t         id;
    vinsn_op_e         op;
    vfu_e              vfu;
    logic              vm;
    logic [VREG_W-1:0] vd;
    logic [VL_W-1:0]   vl;
    logic [VL_W-1:0]   vstart;
    vsew_e             vsew;
  } vfu_operation_t;

  typedef struct packed {
    vinsn_id_t         id;
    logic [VREG_W-1:0] vs;
    logic [VL_W-1:0]   vl;
    logic [VL_W-1:0]   vstart;
    vsew_e             eew;
    logic              reduction_zext;
  } opq_cmd_t;

endpackage

// File: hw/issue/lane_vl_calc.sv
/*
  Splits a vector length and start index across the lanes.
  Elements are spread round-robin, so lanes below the remainder get one more.
  Purely combinational.
*/
module lane_vl_calc import lane_seq_pkg::*; (
  input  logic [LANE_ID_W-1:0] lane_id_i,
  input  logic [VL_W-1:0]      vl_i,
  input  logic [VL_W-1:0]      vstart_i,
  input  vsew_e                vsew_i,
  output logic [VL_W-1:0]      lane_vl_o,
  output logic [VL_W-1:0]      lane_vstart_o,
  output logic [VL_W-1:0]      mask_vl_o
);

  logic            vl_extra;
  logic            vstart_extra;
  logic [VL_W-1:0] mask_words;
  logic [VL_W-1:0] mask_back;

  // Lane share of vl and vstart
  assign vl_extra     = (lane_id_i < vl_i[LANE_ID_W-1:0]);
  assign vstart_extra = (lane_id_i < vstart_i[LANE_ID_W-1:0]);

  assign lane_vl_o     = (vl_i >> LANE_ID_W) + VL_W'(vl_extra);
  assign lane_vstart_o = (vstart_i >> LANE_ID_W) + VL_W'(vstart_extra);

  ////////////////////////////////////////
  // Mask words
  ////////////////////////////////////////

  // The mask request leaves the lane, so a partial word is still fetched
  assign mask_words = vl_i >> (MASK_SHIFT + 32'(vsew_i));
  assign mask_back  = mask_words << (MASK_SHIFT + 32'(vsew_i));
  assign mask_vl_o  = mask_words + VL_W'(mask_back != vl_i);

endmodule

// File: hw/issue/issue_ctrl.sv
/*
  Issue logic of the lane sequencer.
  An instruction issues when its unit's operand slots and the mask slot are
  free and its ID is not running. Zero-length non-reductions are muted.
*/
module issue_ctrl import lane_seq_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic [LANE_ID_W-1:0]  lane_id_i,
  input  pe_req_t               req_i,
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  input  logic [NR_OPQ-1:0]     opq_busy_i,
  input  logic [NR_VINSN-1:0]   running_i,
  output logic [NR_OPQ-1:0]     push_o,
  output opq_cmd_t [NR_OPQ-1:0] cmd_o,
  output logic                  issue_o,
  output vinsn_id_t             issue_id_o,
  output logic                  mute_o,
  output vfu_operation_t        vfu_op_o,
  output logic                  vfu_op_valid_o
);

  logic [VL_W-1:0] lane_vl;
  logic [VL_W-1:0] lane_vstart;
  logic [VL_W-1:0] mask_vl;
  logic            units_busy;
  logic            is_red;
  logic            zero_vl;
  logic            launch;

  lane_vl_calc i_lane_vl_calc (
    .lane_id_i     (lane_id_i),
    .vl_i          (req_i.vl),
    .vstart_i      (req_i.vstart),
    .vsew_i        (req_i.vsew),
    .lane_vl_o     (lane_vl),
    .lane_vstart_o (lane_vstart),
    .mask_vl_o     (mask_vl)
  );

  assign is_red  = req_i.op inside {OP_VREDSUM, OP_VFREDSUM};
  assign zero_vl = (lane_vl == '0);

  // The mask slot is shared by both units
  assign units_busy = opq_busy_i[OPQ_MASK_M] ||
                      ((req_i.vfu == VFU_ALU) ?
                       (opq_busy_i[OPQ_ALU_A] || opq_busy_i[OPQ_ALU_B]) :
                       (opq_busy_i[OPQ_MFPU_A] || opq_busy_i[OPQ_MFPU_B] ||
                        opq_busy_i[OPQ_MFPU_C]));

  assign req_ready_o = !units_busy && !running_i[req_i.id];
  assign issue_o     = req_valid_i && req_ready_o;
  assign issue_id_o  = req_i.id;
  assign mute_o      = issue_o && zero_vl && !is_red;
  assign launch      = issue_o && !mute_o;

  ////////////////////////////////////////
  // Operand queue commands
  ////////////////////////////////////////

  always_comb begin
    // A reduction keeps its scalar in queue A, and needs a neutral element in
    // queue B even when this lane holds no elements
    cmd_o[OPQ_ALU_A] = '{id: req_i.id, vs: req_i.vs1,
                         vl: is_red ? VL_W'(1) : lane_vl,
                         vstart: lane_vstart, eew: req_i.vsew, reduction_zext: zero_vl};
    cmd_o[OPQ_ALU_B] = '{id: req_i.id, vs: req_i.vs2,
                         vl: (is_red && zero_vl) ? VL_W'(1) : lane_vl,
                         vstart: lane_vstart, eew: req_i.vsew, reduction_zext: zero_vl};

    cmd_o[OPQ_MFPU_A] = '{id: req_i.id, vs: req_i.vs1, vl: lane_vl,
                          vstart: lane_vstart, eew: req_i.vsew, reduction_zext: 1'b0};
    cmd_o[OPQ_MFPU_B] = '{id: req_i.id, vs: req_i.swap_vs2_vd_op ? req_i.vd : req_i.vs2,
                          vl: lane_vl, vstart: lane_vstart, eew: req_i.vsew,
                          reduction_zext: 1'b0};
    cmd_o[OPQ_MFPU_C] = '{id: req_i.id, vs: req_i.swap_vs2_vd_op ? req_i.vs2 : req_i.vd,
                          vl: lane_vl, vstart: lane_vstart, eew: req_i.vsew,
                          reduction_zext: 1'b0};

    cmd_o[OPQ_MASK_M] = '{id: req_i.id, vs: VMASK, vl: mask_vl,
                          vstart: lane_vstart, eew: req_i.vsew, reduction_zext: 1'b0};

    push_o = '0;
    if (launch) begin
      if (req_i.vfu == VFU_ALU) begin
        push_o[OPQ_ALU_A] = req_i.use_vs1;
        push_o[OPQ_ALU_B] = req_i.use_vs2;
      end else begin
        push_o[OPQ_MFPU_A] = req_i.use_vs1;
        push_o[OPQ_MFPU_B] = req_i.swap_vs2_vd_op ? req_i.use_vd_op : req_i.use_vs2;
        push_o[OPQ_MFPU_C] = req_i.swap_vs2_vd_op ? req_i.use_vs2 : req_i.use_vd_op;
      end
      push_o[OPQ_MASK_M] = !req_i.vm;
    end
  end

  ////////////////////////////////////////
  // Unit operation register
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vfu_op_valid_o <= 1'b0;
    end else begin
      vfu_op_valid_o <= launch;
    end
  end

  always_ff @(posedge clk_i) begin
    if (launch) begin
      vfu_op_o <= '{id: req_i.id, op: req_i.op, vfu: req_i.vfu, vm: req_i.vm,
                    vd: req_i.vd, vl: lane_vl, vstart: lane_vstart, vsew: req_i.vsew};
    end
  end

endmodule

// File: hw/req_register.sv
/*
  One-entry fall-through buffer for requests.
  While empty it is transparent; it is ready when empty or when its content
  leaves in the same cycle.
*/
module req_register import lane_seq_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  pe_req_t data_i,
  input  logic    valid_i,
  output logic    ready_o,
  output pe_req_t data_o,
  output logic    valid_o,
  input  logic    ready_i
);

  logic    full_q;
  logic    full_d;
  logic    load;
  pe_req_t data_q;

  assign valid_o = full_q | valid_i;
  assign data_o  = full_q ? data_q : data_i;
  assign ready_o = !full_q | ready_i;

  // Store the input unless it passes straight through to the consumer
  assign load = valid_i && ready_o && (full_q || !ready_i);

  always_comb begin
    if (full_q) begin
      full_d = !ready_i || valid_i;
    end else begin
      full_d = valid_i && !ready_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else begin
      full_q <= full_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      data_q <= data_i;
    end
  end

endmodule

// File: hw/operand_cmd_slots.sv
/*
  One held command per operand queue.
  A command stays valid until the requester raises ready for that queue.
  A push in the same cycle as a ready wins over the clear.
*/
module operand_cmd_slots import lane_seq_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic [NR_OPQ-1:0]     push_i,
  input  opq_cmd_t [NR_OPQ-1:0] cmd_i,
  input  logic [NR_OPQ-1:0]     ready_i,
  output opq_cmd_t [NR_OPQ-1:0] cmd_o,
  output logic [NR_OPQ-1:0]     valid_o
);

  logic [NR_OPQ-1:0] valid_d;

  always_comb begin
    for (int q = 0; q < NR_OPQ; q++) begin
      if (push_i[q]) begin
        valid_d[q] = 1'b1;
      end else if (ready_i[q]) begin
        valid_d[q] = 1'b0;
      end else begin
        valid_d[q] = valid_o[q];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_o <= '0;
    end else begin
      valid_o <= valid_d;
    end
  end

  // The payload only changes on a push
  always_ff @(posedge clk_i) begin
    for (int q = 0; q < NR_OPQ; q++) begin
      if (push_i[q]) begin
        cmd_o[q] <= cmd_i[q];
      end
    end
  end

endmodule

// File: hw/vinsn_tracker.sv
/*
  Tracks running and finished instruction IDs of the lane.
  A running bit is set on issue and stays only while the main sequencer
  still reports the ID as running. Done bits last one cycle.
*/
module vinsn_tracker import lane_seq_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                issue_i,
  input  vinsn_id_t           issue_id_i,
  input  logic                mute_i,
  input  logic [NR_VINSN-1:0] pe_running_i,
  input  logic [NR_VINSN-1:0] alu_done_i,
  input  logic [NR_VINSN-1:0] mfpu_done_i,
  output logic [NR_VINSN-1:0] running_o,
  output logic [NR_VINSN-1:0] vinsn_done_o,
  output logic                alu_done_o,
  output logic                mfpu_done_o
);

  logic [NR_VINSN-1:0] running_q;
  logic [NR_VINSN-1:0] running_d;
  logic [NR_VINSN-1:0] done_d;
  logic [NR_VINSN-1:0] issue_bit;

  assign issue_bit = NR_VINSN'(issue_i) << issue_id_i;

  // Bits that the main sequencer has retired drop out right away
  assign running_o = running_q & pe_running_i;
  assign running_d = running_o | issue_bit;

  // A muted instruction is finished the moment it issues
  assign done_d = alu_done_i | mfpu_done_i | (mute_i ? issue_bit : '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q    <= '0;
      vinsn_done_o <= '0;
      alu_done_o   <= 1'b0;
      mfpu_done_o  <= 1'b0;
    end else begin
      running_q    <= running_d;
      vinsn_done_o <= done_d;
      alu_done_o   <= |alu_done_i;
      mfpu_done_o  <= |mfpu_done_i;
    end
  end

endmodule

// File: hw/lane_seq_top.sv
/*
  Sequencer of one vector lane, for the ALU and MFPU paths only.
  A request accepted into an empty register may issue in the same cycle.
  The unit operation and the operand commands appear one cycle after issue.
*/
module lane_seq_top import lane_seq_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [LANE_ID_W-1:0]   lane_id_i,
  // Main sequencer side
  input  pe_req_t                pe_req_i,
  input  logic                   pe_req_valid_i,
  output logic                   pe_req_ready_o,
  input  logic [NR_VINSN-1:0]    pe_vinsn_running_i,
  output pe_resp_t               pe_resp_o,
  // Operand requester side
  output opq_cmd_t [NR_OPQ-1:0]  opq_cmd_o,
  output logic [NR_OPQ-1:0]      opq_valid_o,
  input  logic [NR_OPQ-1:0]      opq_ready_i,
  // Functional unit side
  output vfu_operation_t         vfu_op_o,
  output logic                   vfu_op_valid_o,
  input  logic [NR_VINSN-1:0]    alu_vinsn_done_i,
  input  logic [NR_VINSN-1:0]    mfpu_vinsn_done_i,
  output logic                   alu_vinsn_done_o,
  output logic                   mfpu_vinsn_done_o
);

  pe_req_t               req;
  logic                  req_valid;
  logic                  req_ready;
  logic [NR_OPQ-1:0]     opq_push;
  opq_cmd_t [NR_OPQ-1:0] opq_cmd_new;
  logic                  issue;
  vinsn_id_t             issue_id;
  logic                  mute;
  logic [NR_VINSN-1:0]   running;
  logic [NR_VINSN-1:0]   vinsn_done;

  req_register i_req_register (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .data_i  (pe_req_i),
    .valid_i (pe_req_valid_i),
    .ready_o (pe_req_ready_o),
    .data_o  (req),
    .valid_o (req_valid),
    .ready_i (req_ready)
  );

  issue_ctrl i_issue_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .lane_id_i      (lane_id_i),
    .req_i          (req),
    .req_valid_i    (req_valid),
    .req_ready_o    (req_ready),
    .opq_busy_i     (opq_valid_o),
    .running_i      (running),
    .push_o         (opq_push),
    .cmd_o          (opq_cmd_new),
    .issue_o        (issue),
    .issue_id_o     (issue_id),
    .mute_o         (mute),
    .vfu_op_o       (vfu_op_o),
    .vfu_op_valid_o (vfu_op_valid_o)
  );

  operand_cmd_slots i_operand_cmd_slots (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (opq_push),
    .cmd_i   (opq_cmd_new),
    .ready_i (opq_ready_i),
    .cmd_o   (opq_cmd_o),
    .valid_o (opq_valid_o)
  );

  vinsn_tracker i_vinsn_tracker (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .issue_i      (issue),
    .issue_id_i   (issue_id),
    .mute_i       (mute),
    .pe_running_i (pe_vinsn_running_i),
    .alu_done_i   (alu_vinsn_done_i),
    .mfpu_done_i  (mfpu_vinsn_done_i),
    .running_o    (running),
    .vinsn_done_o (vinsn_done),
    .alu_done_o   (alu_vinsn_done_o),
    .mfpu_done_o  (mfpu_vinsn_done_o)
  );

  assign pe_resp_o.vinsn_done = vinsn_done;

endmodule

// File: sim/lane_seq_sva.sv
/*
  Handshake assertions for the lane sequencer top level.
  Attached by bind; the port names match the top level.
*/
module lane_seq_sva import lane_seq_pkg::*; (
  input logic                  clk_i,
  input logic                  rst_ni,
  input pe_req_t               pe_req_i,
  input logic                  pe_req_valid_i,
  input logic                  pe_req_ready_o,
  input pe_resp_t              pe_resp_o,
  input opq_cmd_t [NR_OPQ-1:0] opq_cmd_o,
  input logic [NR_OPQ-1:0]     opq_valid_o,
  input logic [NR_OPQ-1:0]     opq_ready_i,
  input logic                  vfu_op_valid_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // A pending request may not change or drop before it is taken
  req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pe_req_valid_i && !pe_req_ready_o |=> pe_req_valid_i && $stable(pe_req_i))
    else $error("Request changed while waiting for ready");

  for (genvar q = 0; q < NR_OPQ; q++) begin : g_opq
    cmd_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
      opq_valid_o[q] && !opq_ready_i[q] |=> opq_valid_o[q] && $stable(opq_cmd_o[q]))
      else $error("Operand command %0d changed while held", q);
  end

  reset_quiet: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> (opq_valid_o == '0) && !vfu_op_valid_o &&
                      (pe_resp_o.vinsn_done == '0))
    else $error("Valid output high right after reset");

endmodule

bind lane_seq_top lane_seq_sva i_lane_seq_sva (.*);

// File: sim/tb_lane_seq.sv
/*
  Random testbench for the lane sequencer.
  The lane ID changes only while the DUT is idle. IDs are reused only after done.
  VREDSUM is sent only to the ALU and VFREDSUM only to the MFPU.
*/
module tb_lane_seq import lane_seq_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NR_INSN = 60;
  localparam int TIMEOUT = 2000;

  logic                  clk_i;
  logic                  rst_ni;
  logic [LANE_ID_W-1:0]  lane_id_i;
  pe_req_t               pe_req_i;
  logic                  pe_req_valid_i;
  logic                  pe_req_ready_o;
  logic [NR_VINSN-1:0]   pe_vinsn_running_i;
  pe_resp_t              pe_resp_o;
  opq_cmd_t [NR_OPQ-1:0] opq_cmd_o;
  logic [NR_OPQ-1:0]     opq_valid_o;
  logic [NR_OPQ-1:0]     opq_ready_i;
  vfu_operation_t        vfu_op_o;
  logic                  vfu_op_valid_o;
  logic [NR_VINSN-1:0]   alu_vinsn_done_i;
  logic [NR_VINSN-1:0]   mfpu_vinsn_done_i;
  logic                  alu_vinsn_done_o;
  logic                  mfpu_vinsn_done_o;

  integer              seed = 32'hfa5f;
  int                  err_cnt;
  int                  op_cnt;
  int                  cmd_cnt;
  int                  done_cnt;
  int                  hold_cycles;
  vinsn_id_t           next_id;
  logic [NR_VINSN-1:0] outstanding;
  logic [NR_VINSN-1:0] done_ok;
  int                  countdown [NR_VINSN];
  logic                unit_mfpu [NR_VINSN];
  logic                prev_alu;
  logic                prev_mfpu;
  logic                prev_mask_held;
  vfu_operation_t      exp_op[$];
  opq_cmd_t            exp_cmd[NR_OPQ][$];

  lane_seq_top dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Expected lane operation and operand commands for one request
  function automatic void ref_lane(input pe_req_t req, input int lane,
                                   output vfu_operation_t op,
                                   output opq_cmd_t [NR_OPQ-1:0] cmd,
                                   output logic [NR_OPQ-1:0] push, output logic mute);
    int   vl_share;
    int   vs_share;
    int   mask_w;
    logic red;
    logic zero;
    vl_share = req.vl / NR_LANES + ((lane < req.vl % NR_LANES) ? 1 : 0);
    vs_share = req.vstart / NR_LANES + ((lane < req.vstart % NR_LANES) ? 1 : 0);
    mask_w = (req.vl / (NR_LANES * 8)) >> req.vsew;
    if (((mask_w << req.vsew) * NR_LANES * 8) != int'(req.vl)) mask_w++;
    red  = (req.op == OP_VREDSUM) || (req.op == OP_VFREDSUM);
    zero = (vl_share == 0);
    mute = zero && !red;
    for (int q = 0; q < NR_OPQ; q++) begin
      cmd[q].id             = req.id;
      cmd[q].vl             = VL_W'(vl_share);
      cmd[q].vstart         = VL_W'(vs_share);
      cmd[q].eew            = req.vsew;
      cmd[q].reduction_zext = 1'b0;
    end
    cmd[OPQ_ALU_A].vs             = req.vs1;
    cmd[OPQ_ALU_A].vl             = red ? VL_W'(1) : VL_W'(vl_share);
    cmd[OPQ_ALU_A].reduction_zext = zero;
    cmd[OPQ_ALU_B].vs             = req.vs2;
    cmd[OPQ_ALU_B].vl             = (red && zero) ? VL_W'(1) : VL_W'(vl_share);
    cmd[OPQ_ALU_B].reduction_zext = zero;
    cmd[OPQ_MFPU_A].vs = req.vs1;
    cmd[OPQ_MFPU_B].vs = req.swap_vs2_vd_op ? req.vd : req.vs2;
    cmd[OPQ_MFPU_C].vs = req.swap_vs2_vd_op ? req.vs2 : req.vd;
    cmd[OPQ_MASK_M].vs = VMASK;
    cmd[OPQ_MASK_M].vl = VL_W'(mask_w);
    push = '0;
    if (!mute) begin
      if (req.vfu == VFU_ALU) begin
        push[OPQ_ALU_A] = req.use_vs1;
        push[OPQ_ALU_B] = req.use_vs2;
      end else begin
        push[OPQ_MFPU_A] = req.use_vs1;
        push[OPQ_MFPU_B] = req.swap_vs2_vd_op ? req.use_vd_op : req.use_vs2;
        push[OPQ_MFPU_C] = req.swap_vs2_vd_op ? req.use_vs2 : req.use_vd_op;
      end
      push[OPQ_MASK_M] = !req.vm;
    end
    op = '{id: req.id, op: req.op, vfu: req.vfu, vm: req.vm, vd: req.vd,
           vl: VL_W'(vl_share), vstart: VL_W'(vs_share), vsew: req.vsew};
  endfunction

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_vfu_op(input vfu_operation_t got, input vfu_operation_t exp);
    op_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("FAILED @%0t: vfu op id %0d vl %0d vstart %0d, expected id %0d vl %0d vstart %0d",
               $time, got.id, got.vl, got.vstart, exp.id, exp.vl, exp.vstart);
    end
  endtask

  task automatic check_opq_cmd(input int q, input opq_cmd_t got, input opq_cmd_t exp);
    cmd_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("FAILED @%0t: queue %0d cmd id %0d vs %0d vl %0d zext %0b, expected %0d %0d %0d %0b",
               $time, q, got.id, got.vs, got.vl, got.reduction_zext,
               exp.id, exp.vs, exp.vl, exp.reduction_zext);
    end
  endtask

  task automatic check_done(input vinsn_id_t id);
    done_cnt++;
    if (!outstanding[id] || !done_ok[id]) begin
      err_cnt++;
      $display("FAILED @%0t: done bit for ID %0d came without issue or unit done", $time, id);
    end
    outstanding[id] = 1'b0;
    done_ok[id]     = 1'b0;
  endtask

  task automatic check_pulse(input string unit, input logic got, input logic exp);
    if (got !== exp) begin
      err_cnt++;
      $display("FAILED @%0t: %s done pulse is %0b, expected %0b", $time, unit, got, exp);
    end
  endtask

  task automatic abort(input string reason);
    $display("Timeout: %s", reason);
    $display("Simulation FAILED");
    $finish;
  endtask

  ////////////////////////////////////////
  // Operand requester and unit models
  ////////////////////////////////////////

  always @(posedge clk_i) begin
    #1;
    for (int q = 0; q < NR_OPQ; q++) begin
      opq_ready_i[q] = (hold_cycles == 0) && ($unsigned($random(seed)) % 4 != 0);
    end
    if (hold_cycles > 0) hold_cycles--;
    alu_vinsn_done_i  = '0;
    mfpu_vinsn_done_i = '0;
    for (int k = 0; k < NR_VINSN; k++) begin
      if (countdown[k] > 0) begin
        countdown[k]--;
        if (countdown[k] == 0) begin
          if (unit_mfpu[k]) mfpu_vinsn_done_i[k] = 1'b1;
          else alu_vinsn_done_i[k] = 1'b1;
          done_ok[k] = 1'b1;
        end
      end
    end
    pe_vinsn_running_i = outstanding;
  end

  // Monitor that samples in the middle of the cycle
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (vfu_op_valid_o) begin
        if (prev_mask_held) begin
          err_cnt++;
          $display("FAILED @%0t: instruction issued while the mask slot was held", $time);
        end
        if (exp_op.size() == 0) begin
          err_cnt++;
          $display("FAILED @%0t: unexpected vfu operation", $time);
        end else begin
          check_vfu_op(vfu_op_o, exp_op.pop_front());
        end
        countdown[vfu_op_o.id] = 1 + $unsigned($random(seed)) % 6;
        unit_mfpu[vfu_op_o.id] = (vfu_op_o.vfu == VFU_MFPU);
      end
      for (int q = 0; q < NR_OPQ; q++) begin
        if (opq_valid_o[q] && opq_ready_i[q]) begin
          if (exp_cmd[q].size() == 0) begin
            err_cnt++;
            $display("FAILED @%0t: unexpected command on queue %0d", $time, q);
          end else begin
            check_opq_cmd(q, opq_cmd_o[q], exp_cmd[q].pop_front());
          end
        end
      end
      for (int k = 0; k < NR_VINSN; k++) begin
        if (pe_resp_o.vinsn_done[k]) check_done(vinsn_id_t'(k));
      end
      check_pulse("ALU", alu_vinsn_done_o, prev_alu);
      check_pulse("MFPU", mfpu_vinsn_done_o, prev_mfpu);
    end
    prev_alu       = |alu_vinsn_done_i;
    prev_mfpu      = |mfpu_vinsn_done_i;
    prev_mask_held = opq_valid_o[OPQ_MASK_M] && !opq_ready_i[OPQ_MASK_M];
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic send_random();
    pe_req_t               req;
    vfu_operation_t        op;
    opq_cmd_t [NR_OPQ-1:0] cmd;
    logic [NR_OPQ-1:0]     push;
    logic                  mute;
    logic                  accepted;
    int                    t;
    int                    sel;
    req         = '0;
    req.id      = next_id;
    req.vfu     = vfu_e'($unsigned($random(seed)) % 2);
    sel         = $unsigned($random(seed)) % 4;
    req.op      = (req.vfu == VFU_ALU) ?
                  ((sel == 3) ? OP_VREDSUM : vinsn_op_e'(sel)) :
                  ((sel == 3) ? OP_VFREDSUM : vinsn_op_e'(OP_VMUL + sel));
    req.vm      = 1'($random(seed));
    req.vs1     = VREG_W'($random(seed));
    req.vs2     = VREG_W'($random(seed));
    req.vd      = VREG_W'($random(seed));
    req.use_vs1 = 1'($random(seed));
    req.use_vs2 = 1'($random(seed));
    req.use_vd_op      = 1'($random(seed));
    req.swap_vs2_vd_op = 1'($random(seed));
    sel         = $unsigned($random(seed)) % 4;
    req.vl      = (sel == 0) ? VL_W'($unsigned($random(seed)) % 4) :
                               VL_W'($unsigned($random(seed)) % 300);
    req.vstart  = VL_W'($unsigned($random(seed)) % 8);
    req.vsew    = vsew_e'($unsigned($random(seed)) % 4);
    t = 0;
    while (outstanding[req.id]) begin
      @(negedge clk_i);
      t++;
      if (t > TIMEOUT) abort("an instruction ID never finished");
    end
    @(posedge clk_i);
    #1;
    pe_req_i       = req;
    pe_req_valid_i = 1'b1;
    accepted       = 1'b0;
    t = 0;
    while (!accepted) begin
      @(negedge clk_i);
      if (pe_req_ready_o) begin
        accepted = 1'b1;
      end else begin
        t++;
        if (t > TIMEOUT) abort("a request was never accepted");
      end
    end
    ref_lane(req, int'(lane_id_i), op, cmd, push, mute);
    if (!mute) exp_op.push_back(op);
    for (int q = 0; q < NR_OPQ; q++) begin
      if (push[q]) exp_cmd[q].push_back(cmd[q]);
    end
    outstanding[req.id] = 1'b1;
    done_ok[req.id]     = mute;
    @(posedge clk_i);
    #1;
    pe_req_valid_i = 1'b0;
    next_id++;
  endtask

  task automatic wait_idle();
    int   t;
    logic busy;
    t    = 0;
    busy = 1'b1;
    while (busy) begin
      @(negedge clk_i);
      busy = (outstanding != '0) || (exp_op.size() != 0);
      for (int q = 0; q < NR_OPQ; q++) begin
        if (exp_cmd[q].size() != 0) busy = 1'b1;
      end
      if (busy) begin
        t++;
        if (t > TIMEOUT) abort("the DUT did not drain");
      end
    end
  endtask

  initial begin
    rst_ni             = 1'b0;
    lane_id_i          = '0;
    pe_req_i           = '0;
    pe_req_valid_i     = 1'b0;
    pe_vinsn_running_i = '0;
    opq_ready_i        = '0;
    alu_vinsn_done_i   = '0;
    mfpu_vinsn_done_i  = '0;
    hold_cycles        = 0;
    next_id            = '0;
    outstanding        = '0;
    done_ok            = '0;
    for (int k = 0; k < NR_VINSN; k++) countdown[k] = 0;
    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    for (int lane = 0; lane < NR_LANES; lane++) begin
      @(posedge clk_i);
      #1;
      lane_id_i = LANE_ID_W'(lane);
      for (int n = 0; n < NR_INSN; n++) begin
        // Back-pressure window from the operand requester
        if (n == 20) hold_cycles = 30;
        send_random();
      end
      wait_idle();
    end
    $display("Checks: %0d operations, %0d commands, %0d done bits, %0d errors",
             op_cnt, cmd_cnt, done_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: lane_seq_top.f
common/lane_seq_pkg.sv
hw/issue/lane_vl_calc.sv
hw/issue/issue_ctrl.sv
hw/req_register.sv
hw/operand_cmd_slots.sv
hw/vinsn_tracker.sv
hw/lane_seq_top.sv
sim/lane_seq_sva.sv
sim/tb_lane_seq.sv

// File: Makefile
TOP = tb_lane_seq
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f lane_seq_top.f --top-module $(TOP)

obj_dir/V$(TOP): lane_seq_top.f
	verilator --binary --timing --assert -f lane_seq_top.f --top-module $(TOP) -o V$(TOP)

sim: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "Simulation PASSED" $(LOG)
	! grep -q "Simulation FAILED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
